//--- include/spi_rx_consts.svh
// changing the channel count also needs new ports and channel instances in the top level
`ifndef SPI_RX_CONSTS_SVH
`define SPI_RX_CONSTS_SVH

// queue depth in tagged words
`define SPI_RX_FIFO_DEPTH 8

// number of serial channels in front of the arbiter
`define SPI_RX_NUM_CHAN 2

// value returned when the host reads the control address
`define SPI_RX_VERSION 8'h01

// register map of the 8-bit host bus
`define SPI_RX_ADDR_CTRL   8'd0
`define SPI_RX_ADDR_ENABLE 8'd2
`define SPI_RX_ADDR_LOST0  8'd3
`define SPI_RX_ADDR_LOST1  8'd4

// channel n tags its words with this identifier plus n
`define SPI_RX_ID_BASE 4'h1

`endif

//--- verilog/spi_rx_pkg.sv
// the word layout below is the host visible fifo_data format and must not be reordered

package spi_rx_pkg;

    // index of a receive channel, one bit covers the two channels
    typedef logic chan_idx_t;

    // tagged word as it sits in the queue, identifier in the top nibble
    typedef struct packed {
        logic [3:0]  id;     // channel identifier
        logic [11:0] frame;  // frame number modulo 4096
        logic [15:0] data;   // payload, partial words are right aligned
    } rx_word_t;

endpackage

//--- verilog/word_if.sv
// a source must hold valid, word and src steady until the edge where ready is also high
`timescale 1ns/1ps

interface word_if import spi_rx_pkg::*; ();

    logic      valid;  // source has a word
    logic      ready;  // sink takes the word on this edge
    rx_word_t  word;
    chan_idx_t src;    // channel the word came from

    modport source (
        output valid,
        output word,
        output src,
        input  ready
    );

    modport sink (
        input  valid,
        input  word,
        input  src,
        output ready
    );

endinterface

//--- verilog/spi_frame_rx.sv
// sdi and sen are sampled on SCLK and must already be synchronous to it
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module spi_frame_rx import spi_rx_pkg::*; #(
    parameter logic [3:0] chan_id = `SPI_RX_ID_BASE
) (
    input  logic       SCLK,
    input  logic       RST,
    input  logic       clear,
    input  logic       enable,
    input  logic       sdi,
    input  logic       sen,
    output logic [7:0] lost_count,
    word_if.source     out
);

    localparam logic [3:0] chan_off = chan_id - `SPI_RX_ID_BASE;

    logic        rst_all;
    logic        sen_dly;
    logic        sample;      // a data bit is taken on this edge
    logic        frame_end;   // sen has just fallen
    logic [3:0]  bit_cnt;
    logic [15:0] shift_reg;
    logic        done;        // shift_reg holds a finished word
    logic [11:0] done_frame;
    logic [11:0] frame_cnt;
    logic        hold_valid;
    rx_word_t    hold_word;
    logic        accept;
    logic        load;
    logic        drop;

    assign rst_all   = RST | clear;
    assign sample    = enable & sen;
    assign frame_end = enable & sen_dly & ~sen;

    always_ff @(posedge SCLK) begin
        if (rst_all) begin
            sen_dly <= 1'b0;
        end else begin
            sen_dly <= sen;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // deserializer, bits enter at the bottom so the first bit ends up as the MSB
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge SCLK) begin
        if (rst_all) begin
            bit_cnt   <= '0;
            shift_reg <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (done) begin
                // the finished word leaves this edge and a new word may start at once
                shift_reg <= sample ? {15'b0, sdi} : 16'b0;
                bit_cnt   <= sample ? 4'd1 : 4'd0;
            end else if (sample) begin
                shift_reg <= {shift_reg[14:0], sdi};
                bit_cnt   <= bit_cnt + 4'd1;  // wraps to 0 with the 16th bit
                done      <= (bit_cnt == 4'd15);
            end else if (frame_end && bit_cnt != 4'd0) begin
                bit_cnt <= '0;
                done    <= 1'b1;  // partial word, already right aligned
            end
        end
    end

    // frame number of the word in shift_reg, taken before the frame counter moves
    always_ff @(posedge SCLK) begin
        if ((sample && bit_cnt == 4'd15) || (frame_end && bit_cnt != 4'd0)) begin
            done_frame <= frame_cnt;
        end
    end

    always_ff @(posedge SCLK) begin
        if (rst_all) begin
            frame_cnt <= '0;
        end else if (frame_end) begin
            frame_cnt <= frame_cnt + 12'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one word holding register toward the arbiter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign accept = hold_valid & out.ready;
    assign load   = done & (~hold_valid | accept);  // slot frees on the handshake edge
    assign drop   = done & hold_valid & ~accept;

    always_ff @(posedge SCLK) begin
        if (rst_all) begin
            hold_valid <= 1'b0;
            lost_count <= '0;
        end else begin
            if (load) begin
                hold_valid <= 1'b1;
            end else if (accept) begin
                hold_valid <= 1'b0;
            end
            if (drop && lost_count != 8'hff) begin
                lost_count <= lost_count + 8'd1;  // saturates at 255
            end
        end
    end

    always_ff @(posedge SCLK) begin
        if (load) begin
            hold_word <= '{id: chan_id, frame: done_frame, data: shift_reg};
        end
    end

    assign out.valid = hold_valid;
    assign out.word  = hold_word;
    assign out.src   = chan_idx_t'(chan_off[0]);

endmodule

//--- verilog/word_arbiter.sv
// serves exactly two channels and adds no pipeline stage between the channels and the fifo
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module word_arbiter import spi_rx_pkg::*; (
    input  logic   SCLK,
    input  logic   RST,
    word_if.sink   in0,
    word_if.sink   in1,
    word_if.source out
);

    logic [`SPI_RX_NUM_CHAN-1:0] req;
    chan_idx_t                   prio;   // channel that wins when both wait
    chan_idx_t                   grant;

    assign req = {in1.valid, in0.valid};

    always_comb begin
        if (&req) begin
            grant = prio;
        end else if (req[1]) begin
            grant = 1'b1;
        end else begin
            grant = 1'b0;
        end
    end

    // the winner's word goes straight through to the fifo
    assign out.valid = |req;
    assign out.word  = grant ? in1.word : in0.word;
    assign out.src   = grant ? in1.src : in0.src;

    // only the granted channel sees the fifo's ready
    assign in0.ready = out.ready & (grant == 1'b0);
    assign in1.ready = out.ready & (grant == 1'b1);

    always_ff @(posedge SCLK) begin
        if (RST) begin
            prio <= 1'b0;
        end else if (out.valid && out.ready) begin
            prio <= ~grant;  // the other channel goes first next time
        end
    end

endmodule

//--- verilog/word_fifo.sv
// first word fall through, data is only meaningful while empty is low
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module word_fifo import spi_rx_pkg::*; (
    input  logic     SCLK,
    input  logic     RST,
    input  logic     clear,
    word_if.sink     in,
    input  logic     read,
    output logic     empty,
    output rx_word_t data
);

    localparam int depth = `SPI_RX_FIFO_DEPTH;
    localparam int aw    = $clog2(depth);

    rx_word_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          full;
    logic          push;
    logic          pop;

    assign full     = (count == (aw+1)'(depth));
    assign empty    = (count == '0);
    assign in.ready = ~full;
    assign push     = in.valid & ~full;
    assign pop      = read & ~empty;  // a read on an empty queue is ignored

    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge SCLK) begin
        if (push) begin
            mem[wr_ptr] <= in.word;
        end
    end

    assign data = mem[rd_ptr];

endmodule

//--- verilog/spi_rx_regs.sv
// bus_data_out holds the last read value and a write to the control address resets the receiver
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module spi_rx_regs (
    input  logic       SCLK,
    input  logic       RST,
    input  logic [7:0] bus_add,
    input  logic [7:0] bus_data_in,
    input  logic       bus_wr,
    input  logic       bus_rd,
    output logic [7:0] bus_data_out,
    output logic       clear,
    output logic [1:0] enable,
    input  logic [7:0] lost0,
    input  logic [7:0] lost1
);

    logic ctrl_wr;

    assign ctrl_wr = bus_wr && (bus_add == `SPI_RX_ADDR_CTRL);

    // soft reset pulse, high for the single cycle after the write
    always_ff @(posedge SCLK) begin
        if (RST) begin
            clear <= 1'b0;
        end else begin
            clear <= ctrl_wr;
        end
    end

    always_ff @(posedge SCLK) begin
        if (RST || ctrl_wr) begin
            enable <= '0;
        end else if (bus_wr && bus_add == `SPI_RX_ADDR_ENABLE) begin
            enable <= bus_data_in[1:0];  // bit n enables channel n
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path, one cycle from bus_rd to data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            bus_data_out <= '0;
        end else if (bus_rd) begin
            case (bus_add)
                `SPI_RX_ADDR_CTRL:   bus_data_out <= `SPI_RX_VERSION;
                `SPI_RX_ADDR_ENABLE: bus_data_out <= {6'b0, enable};
                `SPI_RX_ADDR_LOST0:  bus_data_out <= lost0;
                `SPI_RX_ADDR_LOST1:  bus_data_out <= lost1;
                default:             bus_data_out <= 8'h00;
            endcase
        end
    end

endmodule

//--- verilog/spi_rx_top.sv
// all inputs must be synchronous to SCLK since the receiver has no clock domain crossing
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module spi_rx_top (
    input  logic        SCLK,
    input  logic        RST,
    input  logic        sdi0,
    input  logic        sen0,
    input  logic        sdi1,
    input  logic        sen1,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    input  logic [7:0]  bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_wr,
    input  logic        bus_rd,
    output logic [7:0]  bus_data_out
);

    logic                        clear;   // soft reset from the register file
    logic [`SPI_RX_NUM_CHAN-1:0] enable;
    logic [7:0]                  lost0;
    logic [7:0]                  lost1;

    word_if ch0_if ();
    word_if ch1_if ();
    word_if fifo_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial channels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    spi_frame_rx #(.chan_id(`SPI_RX_ID_BASE + 4'd0)) u_chan0 (
        .SCLK       (SCLK),
        .RST        (RST),
        .clear      (clear),
        .enable     (enable[0]),
        .sdi        (sdi0),
        .sen        (sen0),
        .lost_count (lost0),
        .out        (ch0_if.source)
    );

    spi_frame_rx #(.chan_id(`SPI_RX_ID_BASE + 4'd1)) u_chan1 (
        .SCLK       (SCLK),
        .RST        (RST),
        .clear      (clear),
        .enable     (enable[1]),
        .sdi        (sdi1),
        .sen        (sen1),
        .lost_count (lost1),
        .out        (ch1_if.source)
    );

    word_arbiter u_arb (
        .SCLK (SCLK),
        .RST  (RST),
        .in0  (ch0_if.sink),
        .in1  (ch1_if.sink),
        .out  (fifo_if.source)
    );

    word_fifo u_fifo (
        .SCLK  (SCLK),
        .RST   (RST),
        .clear (clear),
        .in    (fifo_if.sink),
        .read  (fifo_read),
        .empty (fifo_empty),
        .data  (fifo_data)  // packed rx_word_t, id in bits 31 to 28
    );

    spi_rx_regs u_regs (
        .SCLK         (SCLK),
        .RST          (RST),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .clear        (clear),
        .enable       (enable),
        .lost0        (lost0),
        .lost1        (lost1)
    );

endmodule

//--- bench/spi_rx_asserts.sv
// head and level are checked only on the fifo instance, the channel handshakes only on the arbiter
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module spi_rx_asserts #(
    parameter bit is_fifo = 1'b1
) (
    input logic                                 SCLK,
    input logic                                 RST,
    input logic                                 clear,
    input logic                                 valid,
    input logic                                 ready,
    input logic [31:0]                          word,
    input logic [31:0]                          head,
    input logic [$clog2(`SPI_RX_FIFO_DEPTH):0]  level,
    input logic                                 valid0,
    input logic                                 valid1,
    input logic                                 ready0,
    input logic                                 ready1
);

    // an offered word never carries unknown bits
    a_word_known: assert property (@(posedge SCLK) disable iff (RST)
        valid |-> !$isunknown(word))
        else $error("word has unknown bits while valid is high");

    if (is_fifo) begin : g_fifo
        // a word written into an empty queue shows up at the head one cycle later
        a_fall_through: assert property (@(posedge SCLK) disable iff (RST)
            (valid && ready && !clear && level == '0) |=> (head == $past(word)))
            else $error("word written into the empty fifo is not at its head");
    end else begin : g_arb
        a_serve: assert property (@(posedge SCLK) disable iff (RST)
            ((valid0 || valid1) && ready) |-> ((valid0 && ready0) || (valid1 && ready1)))
            else $error("a waiting channel was not served while the fifo had room");
    end

endmodule

bind word_fifo spi_rx_asserts #(.is_fifo(1'b1)) u_fifo_chk (
    .SCLK (SCLK), .RST (RST), .clear (clear), .valid (in.valid), .ready (in.ready),
    .word (in.word), .head (data), .level (count),
    .valid0 (1'b0), .valid1 (1'b0), .ready0 (1'b0), .ready1 (1'b0)
);

bind word_arbiter spi_rx_asserts #(.is_fifo(1'b0)) u_arb_chk (
    .SCLK (SCLK), .RST (RST), .clear (1'b0), .valid (out.valid), .ready (out.ready),
    .word (out.word), .head ('0), .level ('0),
    .valid0 (in0.valid), .valid1 (in1.valid), .ready0 (in0.ready), .ready1 (in1.ready)
);

//--- bench/spi_rx_tb.sv
// run from the project root, and every hold record must start with an empty fifo
`timescale 1ns/1ps
`include "spi_rx_consts.svh"

module spi_rx_tb;

    logic        SCLK;
    logic        RST;
    logic        sdi0;
    logic        sen0;
    logic        sdi1;
    logic        sen1;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic [7:0]  bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_out;

    // records of the cases file
    string       rec_name [64];
    string       rec_op [64];
    int          rec_arg [64];   // channel or bus address
    int          rec_bits [64];
    logic [63:0] rec_data [64];
    logic [63:0] rec_exp [64];
    int          n_rec;
    int          total_bits;

    // reference model state
    logic [31:0] exp_q0 [$];
    logic [31:0] exp_q1 [$];
    logic [11:0] frame_model [2];
    logic [1:0]  en_model;
    logic        bits0 [0:511];
    logic        bits1 [0:511];
    logic [31:0] rnd_state;

    string       cur_name;
    int          test_err;
    int          total_err;
    int          n_tests;
    int          n_failed;
    int          fd;
    int          wd_limit;
    bit          wd_arm = 1'b0;

    spi_rx_top uut (
        .SCLK (SCLK), .RST (RST),
        .sdi0 (sdi0), .sen0 (sen0), .sdi1 (sdi1), .sen1 (sen1),
        .fifo_read (fifo_read), .fifo_empty (fifo_empty), .fifo_data (fifo_data),
        .bus_add (bus_add), .bus_data_in (bus_data_in), .bus_wr (bus_wr),
        .bus_rd (bus_rd), .bus_data_out (bus_data_out)
    );

    initial SCLK = 1'b0;
    always #20 SCLK = ~SCLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_cond(input bit ok, input string msg);
        assert (ok) else begin
            $display("Error in %s: %s", cur_name, msg);
            test_err++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model, MSB first words of 16 bits and a right aligned tail
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_frame(input int c, input int n, input int keep);
        logic [15:0] d;
        logic [31:0] w;
        int          i;
        int          k;
        int          taken;
        if (en_model[c]) begin
            taken = 0;
            for (i = 0; i < n; i = i + 16) begin
                d = '0;
                for (k = i; k < n && k < i + 16; k++) begin
                    d = {d[14:0], (c == 0) ? bits0[k] : bits1[k]};
                end
                w = {`SPI_RX_ID_BASE + 4'(c), frame_model[c], d};
                if (taken < keep && c == 0) begin
                    exp_q0.push_back(w);
                end else if (taken < keep) begin
                    exp_q1.push_back(w);
                end
                taken++;  // words past keep are lost in the DUT
            end
            frame_model[c] = frame_model[c] + 12'd1;
        end
    endtask

    task automatic send_frame(input logic [1:0] mask, input int n, input logic [63:0] d,
                              input bit use_rand, input int keep);
        int k;
        for (k = 0; k < n; k++) begin
            if (use_rand) begin
                rnd_state = lcg_next(rnd_state);
                bits0[k]  = rnd_state[31];
                rnd_state = lcg_next(rnd_state);
                bits1[k]  = rnd_state[31];
            end else begin
                bits0[k] = d[n-1-k];
                bits1[k] = ~d[n-1-k];  // the second channel sends the inverse
            end
        end
        for (k = 0; k < n; k++) begin
            @(negedge SCLK);
            sen0 = mask[0];
            sdi0 = mask[0] & bits0[k];
            sen1 = mask[1];
            sdi1 = mask[1] & bits1[k];
        end
        @(negedge SCLK);
        sen0 = 1'b0;
        sdi0 = 1'b0;
        sen1 = 1'b0;
        sdi1 = 1'b0;
        if (mask[0]) model_frame(0, n, keep);
        if (mask[1]) model_frame(1, n, keep);
    endtask

    // pops until the fifo has stayed empty for eight cycles
    task automatic drain(output int got);
        logic [31:0] w;
        int          idle;
        int          c;
        got  = 0;
        idle = 0;
        while (idle < 8) begin
            @(negedge SCLK);
            fifo_read = 1'b0;
            if (!fifo_empty) begin
                w         = fifo_data;
                fifo_read = 1'b1;
                idle      = 0;
                got++;
                c = int'(w[31:28]) - int'(`SPI_RX_ID_BASE);
                if (c == 0 && exp_q0.size() > 0) begin
                    check_value("channel 0 word", exp_q0.pop_front(), w);
                end else if (c == 1 && exp_q1.size() > 0) begin
                    check_value("channel 1 word", exp_q1.pop_front(), w);
                end else begin
                    check_cond(1'b0, $sformatf("unexpected word %h came out of the FIFO", w));
                end
            end else begin
                idle++;
            end
        end
    endtask

    task automatic bus_write(input int addr, input logic [7:0] val);
        @(negedge SCLK);
        bus_add     = 8'(addr);
        bus_data_in = val;
        bus_wr      = 1'b1;
        @(negedge SCLK);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [7:0] val);
        @(negedge SCLK);
        bus_add = 8'(addr);
        bus_rd  = 1'b1;
        @(negedge SCLK);
        bus_rd = 1'b0;
        val    = bus_data_out;  // registered on the edge in between
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_cases();
        string tok;
        string line;
        int    r;
        n_rec      = 0;
        total_bits = 0;
        while (!$feof(fd) && n_rec < 64) begin
            r = $fscanf(fd, "%s", tok);
            if (r == 1 && tok.substr(0, 0) == "#") begin
                r = $fgets(line, fd);
            end else if (r == 1) begin
                rec_name[n_rec] = tok;
                r = $fscanf(fd, "%s %d %d %h %h", rec_op[n_rec], rec_arg[n_rec],
                            rec_bits[n_rec], rec_data[n_rec], rec_exp[n_rec]);
                total_bits += rec_bits[n_rec];
                n_rec++;
            end
        end
    endtask

    task automatic do_record(input int i);
        logic [7:0] v;
        int         got;
        if (rec_op[i] == "wr") begin
            bus_write(rec_arg[i], rec_data[i][7:0]);
            if (rec_arg[i] == `SPI_RX_ADDR_ENABLE) en_model = rec_data[i][1:0];
        end else if (rec_op[i] == "rd") begin
            bus_read(rec_arg[i], v);
            check_value($sformatf("read of address %0d", rec_arg[i]), rec_exp[i][31:0], v);
        end else if (rec_op[i] == "frame" || rec_op[i] == "both") begin
            send_frame((rec_op[i] == "both") ? 2'b11 : 2'(1 << rec_arg[i]), rec_bits[i],
                       rec_data[i], 1'b0, 4096);
            drain(got);
            check_value("word count", rec_exp[i][31:0], got);
            check_cond(exp_q0.size() == 0 && exp_q1.size() == 0,
                       "expected words never came out of the FIFO");
        end else if (rec_op[i] == "hold") begin
            send_frame(2'(1 << rec_arg[i]), rec_bits[i], '0, 1'b1, `SPI_RX_FIFO_DEPTH + 1);
        end else if (rec_op[i] == "drain") begin
            drain(got);
            check_value("word count", rec_exp[i][31:0], got);
        end else if (rec_op[i] == "soft") begin
            bus_write(`SPI_RX_ADDR_CTRL, 8'h00);
            en_model = 2'b00;
            frame_model[0] = '0;
            frame_model[1] = '0;
            exp_q0.delete();
            exp_q1.delete();
            repeat (2) @(negedge SCLK);
            check_cond(fifo_empty, "FIFO still holds words after the soft reset");
        end else begin
            check_cond(1'b0, {"unknown operation ", rec_op[i]});
        end
    endtask

    task automatic finish_test();
        if (cur_name != "") begin
            n_tests++;
            if (test_err == 0) begin
                $display("test %s: ok", cur_name);
            end else begin
                $display("test %s: %0d errors", cur_name, test_err);
                n_failed++;
            end
            total_err += test_err;
            test_err = 0;
        end
    endtask

    task automatic run_cases();
        int i;
        for (i = 0; i < n_rec; i++) begin
            if (rec_name[i] != cur_name) begin
                finish_test();
                cur_name = rec_name[i];
            end
            do_record(i);
        end
        finish_test();
        $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                 n_tests, n_tests - n_failed, n_failed, total_err);
        if (total_err == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin
        RST         = 1'b1;
        sdi0        = 1'b0;
        sen0        = 1'b0;
        sdi1        = 1'b0;
        sen1        = 1'b0;
        fifo_read   = 1'b0;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        rnd_state   = 32'hdcfc_5d4d;
        en_model    = 2'b00;
        frame_model[0] = '0;
        frame_model[1] = '0;
        cur_name  = "";
        test_err  = 0;
        total_err = 0;
        n_tests   = 0;
        n_failed  = 0;
        fd = $fopen("bench/spi_rx_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/spi_rx_cases.txt");
            $display("Verification failed");
            $finish;
        end else begin
            load_cases();
            $fclose(fd);
            wd_limit = total_bits * 4 + 2000;
            wd_arm   = 1'b1;
            repeat (5) @(posedge SCLK);
            @(negedge SCLK);
            RST = 1'b0;
            run_cases();
        end
    end

    // watchdog scaled by the number of serial bits in the cases file
    initial begin
        wait (wd_arm);
        repeat (wd_limit) @(posedge SCLK);
        $display("timeout: the run did not finish within %0d cycles", wd_limit);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- bench/spi_rx_cases.txt
# name op arg bits data expect, arg is the channel or the bus address, data and expect in hex
# frame, both and drain expect a word count, rd expects the byte read, hold sends random bits
whole    wr    2 0   01           0
whole    frame 0 48  123456789abc 3
whole    frame 0 48  fedcba987654 3
partial  frame 0 20  abcde        2
share    wr    2 0   03           0
share    both  0 48  0123456789ab 6
share    both  0 20  5a5a5        4
enable   wr    2 0   01           0
enable   frame 1 32  deadbeef     0
enable   rd    2 0   0            01
enable   rd    0 0   0            01
enable   wr    2 0   02           0
enable   frame 1 16  beef         1
overflow wr    2 0   01           0
overflow hold  0 192 0            0
overflow rd    3 0   0            03
overflow drain 0 0   0            9
softrst  wr    2 0   03           0
softrst  hold  1 48  0            0
softrst  soft  0 0   0            0
softrst  rd    3 0   0            00
softrst  rd    2 0   0            00
softrst  wr    2 0   03           0
softrst  frame 0 16  1234         1
softrst  frame 1 16  5678         1

//--- project.f
+incdir+include
verilog/spi_rx_pkg.sv
verilog/word_if.sv
verilog/spi_frame_rx.sv
verilog/word_arbiter.sv
verilog/word_fifo.sv
verilog/spi_rx_regs.sv
verilog/spi_rx_top.sv
bench/spi_rx_asserts.sv
bench/spi_rx_tb.sv

//--- Bender.yml
package:
  name: spi_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/spi_rx_pkg.sv
      - verilog/word_if.sv
      - verilog/spi_frame_rx.sv
      - verilog/word_arbiter.sv
      - verilog/word_fifo.sv
      - verilog/spi_rx_regs.sv
      - verilog/spi_rx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/spi_rx_asserts.sv
      - bench/spi_rx_tb.sv
